// File: decodePkg.sv
// Shared micro-op types and codes; encodings are local to this core and not tied to any ISA spec
package decodePkg;

	// ========================================
	// Sizes
	// ========================================

	// Entries held by each skid buffer before its ready drops
	localparam int BUF_DEPTH = 2;

	// ========================================
	// Opcodes
	// ========================================

	// Scalar register forms, one per operand size
	localparam logic [6:0] OP_R3B = 7'd2;
	localparam logic [6:0] OP_R3W = 7'd3;
	localparam logic [6:0] OP_R3T = 7'd4;
	localparam logic [6:0] OP_R3O = 7'd5;

	// Paired register forms of the same four sizes
	localparam logic [6:0] OP_R3BP = 7'd6;
	localparam logic [6:0] OP_R3WP = 7'd7;
	localparam logic [6:0] OP_R3TP = 7'd8;
	localparam logic [6:0] OP_R3OP = 7'd9;

	// Paired octa form kept as a separate opcode for older code streams
	localparam logic [6:0] OP_R3P = 7'd10;

	// Immediate forms carry a 13-bit immediate in rs2 and func
	localparam logic [6:0] OP_ADDI = 7'd16;
	localparam logic [6:0] OP_MULUI = 7'd17;
	localparam logic [6:0] OP_MULI = 7'd18;
	localparam logic [6:0] OP_DIVUI = 7'd19;
	localparam logic [6:0] OP_DIVI = 7'd20;

	// Memory and control flow
	localparam logic [6:0] OP_LOAD = 7'd32;
	localparam logic [6:0] OP_STORE = 7'd33;
	localparam logic [6:0] OP_BRANCH = 7'd40;

	// ========================================
	// Function codes of the R3 family
	// ========================================

	localparam logic [6:0] FN_ADD = 7'd0;
	localparam logic [6:0] FN_SUB = 7'd1;
	localparam logic [6:0] FN_AND = 7'd8;
	localparam logic [6:0] FN_OR = 7'd9;
	localparam logic [6:0] FN_MULU = 7'd16;
	localparam logic [6:0] FN_MUL = 7'd17;
	localparam logic [6:0] FN_DIVU = 7'd20;
	localparam logic [6:0] FN_DIV = 7'd21;

	// Functional unit that executes the micro-op
	typedef enum logic [2:0] {
		UNIT_ALU = 3'd0,
		UNIT_MUL = 3'd1,
		UNIT_DIV = 3'd2,
		UNIT_MEM = 3'd3,
		UNIT_BR = 3'd4
	} unit_t;

	// Operand size where everything outside the R3 family counts as octa
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_WYDE = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA = 2'd3
	} size_t;

	// Raw micro-op as it leaves the fetch queue with its opcode in the top bits
	typedef struct packed {
		logic [6:0] opcode;
		logic [5:0] rd;
		logic [5:0] rs1;
		logic [5:0] rs2;
		logic [6:0] func;
	} microOp_t;

	// Decoded record handed to the issue logic
	typedef struct packed {
		logic [5:0] rd;
		logic [5:0] rs1;
		logic [5:0] rs2;
		unit_t unit;
		size_t size;
		logic pair;
		logic isImm;
		logic [12:0] imm;
		logic divu;
		logic div;
		logic mulu;
		logic mul;
		logic illegal;
	} decodedUop_t;

endpackage

// File: uopSkidBuffer.sv
// Two-entry valid/ready buffer; inData must stay stable while inValid is high and not yet taken
module uopSkidBuffer import decodePkg::*;
#(
	parameter type payload_t = microOp_t
)
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input payload_t inData,
	output logic outValid,
	input logic outReady,
	output payload_t outData
);

	// The main entry drives the output and the skid entry catches an item during a stall
	logic mainValid;
	logic skidValid;
	payload_t mainData;
	payload_t skidData;
	logic readyReg;
	logic inFire;
	logic outFire;
	logic mainFree;
	logic mainFromSkid;
	logic mainFromIn;
	logic skidLoad;
	logic nextMainValid;
	logic nextSkidValid;
	logic [1:0] nextCount;

	assign inFire = inValid & readyReg;
	assign outFire = mainValid & outReady;

	// ========================================
	// Next state
	// ========================================

	always_comb
	begin
		// The main entry can take a new item when it is empty or drains this cycle
		mainFree = ~mainValid | outFire;
		// An item parked in the skid entry always moves up before new input
		mainFromSkid = mainFree & skidValid;
		mainFromIn = mainFree & ~skidValid & inFire;
		// Input arriving while the output stalls lands in the skid entry
		skidLoad = ~mainFree & inFire;
		nextMainValid = mainFree ? (skidValid | inFire) : 1'b1;
		nextSkidValid = mainFree ? 1'b0 : (skidValid | inFire);
		nextCount = {1'b0, nextMainValid} + {1'b0, nextSkidValid};
	end

	// Control state with a registered ready that cuts the ready path between stages
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			mainValid <= 1'b0;
			skidValid <= 1'b0;
			readyReg <= 1'b1;
		end
		else
		begin
			mainValid <= nextMainValid;
			skidValid <= nextSkidValid;
			readyReg <= nextCount < BUF_DEPTH;
		end
	end

	// Payload storage
	always_ff @(posedge clk)
	begin
		if (mainFromSkid)
			mainData <= skidData;
		else if (mainFromIn)
			mainData <= inData;
		if (skidLoad)
			skidData <= inData;
	end

	assign inReady = readyReg;
	assign outValid = mainValid;
	assign outData = mainData;

endmodule

// File: uopDecodeDiv.sv
// Flags divide micro-ops only; it does not check that the rest of the micro-op is legal
module uopDecodeDiv import decodePkg::*;
(
	input microOp_t uop,
	output logic divu,
	output logic div
);

	// ========================================
	// R3 family membership
	// ========================================

	// Any of the nine register forms, scalar or paired
	function automatic logic fnIsR3(input microOp_t ir);
		fnIsR3 =
			ir.opcode == OP_R3B ||
			ir.opcode == OP_R3W ||
			ir.opcode == OP_R3T ||
			ir.opcode == OP_R3O ||
			ir.opcode == OP_R3BP ||
			ir.opcode == OP_R3WP ||
			ir.opcode == OP_R3TP ||
			ir.opcode == OP_R3OP ||
			ir.opcode == OP_R3P;
	endfunction

	// Unsigned divide by immediate, or register form with the DIVU function
	function automatic logic fnIsDivu(input microOp_t ir);
		fnIsDivu = ir.opcode == OP_DIVUI || (fnIsR3(ir) && ir.func == FN_DIVU);
	endfunction

	// Signed divide follows the same pattern
	function automatic logic fnIsDiv(input microOp_t ir);
		fnIsDiv = ir.opcode == OP_DIVI || (fnIsR3(ir) && ir.func == FN_DIV);
	endfunction

	// ========================================
	// Outputs
	// ========================================

	assign divu = fnIsDivu(uop);
	assign div = fnIsDiv(uop);

endmodule

// File: uopDecodeMul.sv
// Flags multiply micro-ops only; it does not check that the rest of the micro-op is legal
module uopDecodeMul import decodePkg::*;
(
	input microOp_t uop,
	output logic mulu,
	output logic mul
);

	// ========================================
	// R3 family membership
	// ========================================

	// Same nine register forms that the divide detector accepts
	function automatic logic fnIsR3(input microOp_t ir);
		fnIsR3 =
			ir.opcode == OP_R3B ||
			ir.opcode == OP_R3W ||
			ir.opcode == OP_R3T ||
			ir.opcode == OP_R3O ||
			ir.opcode == OP_R3BP ||
			ir.opcode == OP_R3WP ||
			ir.opcode == OP_R3TP ||
			ir.opcode == OP_R3OP ||
			ir.opcode == OP_R3P;
	endfunction

	// Unsigned multiply by immediate, or register form with the MULU function
	function automatic logic fnIsMulu(input microOp_t ir);
		fnIsMulu = ir.opcode == OP_MULUI || (fnIsR3(ir) && ir.func == FN_MULU);
	endfunction

	// Signed multiply, immediate or register form
	function automatic logic fnIsMul(input microOp_t ir);
		fnIsMul = ir.opcode == OP_MULI || (fnIsR3(ir) && ir.func == FN_MUL);
	endfunction

	// ========================================
	// Outputs
	// ========================================

	assign mulu = fnIsMulu(uop);
	assign mul = fnIsMul(uop);

endmodule

// File: uopDecodeCore.sv
// Purely combinational decode; it has no valid input, so its output is only meaningful with one
module uopDecodeCore import decodePkg::*;
(
	input microOp_t uop,
	output decodedUop_t dec
);

	logic divu;
	logic div;
	logic mulu;
	logic mul;
	logic knownOp;
	logic isR3;
	logic funcOk;
	logic isImm;
	logic isMem;
	logic isBr;
	logic opPair;
	size_t opSize;
	logic illegal;

	uopDecodeDiv uopDecodeDiv_i (
		.uop(uop),
		.divu(divu),
		.div(div)
	);

	uopDecodeMul uopDecodeMul_i (
		.uop(uop),
		.mulu(mulu),
		.mul(mul)
	);

	// ========================================
	// Opcode class
	// ========================================

	always_comb
	begin
		// Defaults describe an octa, unpaired, register-only micro-op
		knownOp = 1'b1;
		isR3 = 1'b0;
		isImm = 1'b0;
		isMem = 1'b0;
		isBr = 1'b0;
		opPair = 1'b0;
		opSize = SZ_OCTA;
		case (uop.opcode)
			OP_R3B, OP_R3BP:
			begin
				isR3 = 1'b1;
				opSize = SZ_BYTE;
				opPair = uop.opcode == OP_R3BP;
			end
			OP_R3W, OP_R3WP:
			begin
				isR3 = 1'b1;
				opSize = SZ_WYDE;
				opPair = uop.opcode == OP_R3WP;
			end
			OP_R3T, OP_R3TP:
			begin
				isR3 = 1'b1;
				opSize = SZ_TETRA;
				opPair = uop.opcode == OP_R3TP;
			end
			// Both paired octa encodings decode the same way
			OP_R3O, OP_R3OP, OP_R3P:
			begin
				isR3 = 1'b1;
				opPair = uop.opcode != OP_R3O;
			end
			OP_ADDI, OP_MULUI, OP_MULI, OP_DIVUI, OP_DIVI:
				isImm = 1'b1;
			OP_LOAD, OP_STORE:
				isMem = 1'b1;
			OP_BRANCH:
				isBr = 1'b1;
			default:
				knownOp = 1'b0;
		endcase
	end

	// Only R3 forms look at func because other classes reuse those bits
	always_comb
	begin
		case (uop.func)
			FN_ADD, FN_SUB, FN_AND, FN_OR, FN_MULU, FN_MUL, FN_DIVU, FN_DIV:
				funcOk = 1'b1;
			default:
				funcOk = 1'b0;
		endcase
	end

	assign illegal = ~knownOp | (isR3 & ~funcOk);

	// ========================================
	// Record assembly
	// ========================================

	always_comb
	begin
		dec.rd = uop.rd;
		dec.rs1 = uop.rs1;
		dec.rs2 = uop.rs2;
		// Divide wins over multiply, though no legal code sets both
		if (illegal)
			dec.unit = UNIT_ALU;
		else if (divu | div)
			dec.unit = UNIT_DIV;
		else if (mulu | mul)
			dec.unit = UNIT_MUL;
		else if (isMem)
			dec.unit = UNIT_MEM;
		else if (isBr)
			dec.unit = UNIT_BR;
		else
			dec.unit = UNIT_ALU;
		dec.size = opSize;
		dec.pair = opPair;
		dec.isImm = isImm;
		// The immediate spans the whole field, so its top bit is already the sign bit
		dec.imm = isImm ? {uop.rs2, uop.func} : 13'd0;
		dec.divu = divu & ~illegal;
		dec.div = div & ~illegal;
		dec.mulu = mulu & ~illegal;
		dec.mul = mul & ~illegal;
		dec.illegal = illegal;
	end

endmodule

// File: uopDecodeStage.sv
// Decode stage with two edges of latency; up to four micro-ops may sit inside under back-pressure
module uopDecodeStage import decodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input microOp_t inUop,
	output logic outValid,
	input logic outReady,
	output decodedUop_t outDec
);

	// ========================================
	// Internal wires
	// ========================================

	// Middle handshake between the two buffers with the decode on its data path
	logic midValid;
	logic midReady;
	microOp_t midUop;
	decodedUop_t midDec;

	// Input side registers the raw micro-op
	uopSkidBuffer #(
		.payload_t(microOp_t)
	) inBuf (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inUop),
		.outValid(midValid),
		.outReady(midReady),
		.outData(midUop)
	);

	// Decode adds no cycle and carries no valid of its own
	uopDecodeCore uopDecodeCore_i (
		.uop(midUop),
		.dec(midDec)
	);

	// Output side registers the decoded record
	// Its ready feeds back to the input buffer
	uopSkidBuffer #(
		.payload_t(decodedUop_t)
	) outBuf (
		.clk(clk),
		.arstN(arstN),
		.inValid(midValid),
		.inReady(midReady),
		.inData(midDec),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outDec)
	);

endmodule

// File: tbUopDecodeStage.sv
// Self-checking testbench for the decode stage; random mix uses a fixed seed, runs under Verilator
module tbUopDecodeStage import decodePkg::*;
();

	logic clk;
	logic arstN;
	logic inValid;
	logic inReady;
	microOp_t inUop;
	logic outValid;
	logic outReady;
	decodedUop_t outDec;

	// Scoreboard state shared by the stimulus and the comparison process
	decodedUop_t expQueue[$];
	int cycleQueue[$];
	int seed;
	int cycleCount;
	int checkCount;
	int errorCount;
	int timeoutCount;
	int acceptedCount;
	int deliveredCount;
	int sentCount;
	int timeoutCycles;
	logic latencyCheck;
	logic stalled;
	decodedUop_t heldDec;

	uopDecodeStage uopDecodeStage_i (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.inUop(inUop),
		.outValid(outValid),
		.outReady(outReady),
		.outDec(outDec)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Reference model and stimulus helpers
	// ========================================

	// Expected record built from the decode rules of the stage
	function automatic decodedUop_t refDecode(input microOp_t u);
		decodedUop_t d;
		logic r3;
		logic known;
		logic illegal;
		begin
			d = '0;
			d.rd = u.rd;
			d.rs1 = u.rs1;
			d.rs2 = u.rs2;
			d.size = SZ_OCTA;
			r3 = 1'b1;
			known = 1'b1;
			case (u.opcode)
				OP_R3B: d.size = SZ_BYTE;
				OP_R3W: d.size = SZ_WYDE;
				OP_R3T: d.size = SZ_TETRA;
				OP_R3O: d.size = SZ_OCTA;
				OP_R3BP:
				begin
					d.size = SZ_BYTE;
					d.pair = 1'b1;
				end
				OP_R3WP:
				begin
					d.size = SZ_WYDE;
					d.pair = 1'b1;
				end
				OP_R3TP:
				begin
					d.size = SZ_TETRA;
					d.pair = 1'b1;
				end
				OP_R3OP, OP_R3P: d.pair = 1'b1;
				default:
				begin
					r3 = 1'b0;
					known = u.opcode inside {OP_ADDI, OP_MULUI, OP_MULI, OP_DIVUI, OP_DIVI,
						OP_LOAD, OP_STORE, OP_BRANCH};
				end
			endcase
			// Immediate forms take rs2 and func as one 13-bit signed value
			d.isImm = u.opcode inside {OP_ADDI, OP_MULUI, OP_MULI, OP_DIVUI, OP_DIVI};
			if (d.isImm)
				d.imm = {u.rs2, u.func};
			illegal = !known ||
				(r3 && !(u.func inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_MULU, FN_MUL,
				FN_DIVU, FN_DIV}));
			d.illegal = illegal;
			if (!illegal)
			begin
				d.divu = u.opcode == OP_DIVUI || (r3 && u.func == FN_DIVU);
				d.div = u.opcode == OP_DIVI || (r3 && u.func == FN_DIV);
				d.mulu = u.opcode == OP_MULUI || (r3 && u.func == FN_MULU);
				d.mul = u.opcode == OP_MULI || (r3 && u.func == FN_MUL);
				if (d.divu || d.div)
					d.unit = UNIT_DIV;
				else if (d.mulu || d.mul)
					d.unit = UNIT_MUL;
				else if (u.opcode == OP_LOAD || u.opcode == OP_STORE)
					d.unit = UNIT_MEM;
				else if (u.opcode == OP_BRANCH)
					d.unit = UNIT_BR;
			end
			refDecode = d;
		end
	endfunction

	// The nine register forms with the scalar ones first
	function automatic logic [6:0] r3Opcode(input int idx);
		case (idx)
			0: r3Opcode = OP_R3B;
			1: r3Opcode = OP_R3W;
			2: r3Opcode = OP_R3T;
			3: r3Opcode = OP_R3O;
			4: r3Opcode = OP_R3BP;
			5: r3Opcode = OP_R3WP;
			6: r3Opcode = OP_R3TP;
			7: r3Opcode = OP_R3OP;
			default: r3Opcode = OP_R3P;
		endcase
	endfunction

	function automatic logic [6:0] fnCode(input int idx);
		case (idx)
			0: fnCode = FN_DIVU;
			1: fnCode = FN_DIV;
			2: fnCode = FN_MULU;
			3: fnCode = FN_MUL;
			4: fnCode = FN_ADD;
			5: fnCode = FN_SUB;
			6: fnCode = FN_AND;
			default: fnCode = FN_OR;
		endcase
	endfunction

	// Immediate forms at 0 to 4, then load, store and branch
	function automatic logic [6:0] otherOpcode(input int idx);
		case (idx)
			0: otherOpcode = OP_ADDI;
			1: otherOpcode = OP_MULUI;
			2: otherOpcode = OP_MULI;
			3: otherOpcode = OP_DIVUI;
			4: otherOpcode = OP_DIVI;
			5: otherOpcode = OP_LOAD;
			6: otherOpcode = OP_STORE;
			default: otherOpcode = OP_BRANCH;
		endcase
	endfunction

	// Weighted mix of legal R3, other legal forms, R3 with a bad func and unknown opcodes
	function automatic microOp_t randomUop();
		microOp_t u;
		int pick;
		begin
			u = $random(seed);
			pick = {$random(seed)} % 100;
			if (pick < 45)
			begin
				u.opcode = r3Opcode({$random(seed)} % 9);
				u.func = fnCode({$random(seed)} % 8);
			end
			else if (pick < 72)
				u.opcode = otherOpcode({$random(seed)} % 8);
			else if (pick < 86)
			begin
				u.opcode = r3Opcode({$random(seed)} % 9);
				u.func = 7'd22 + 7'({$random(seed)} % 100);
			end
			else
				u.opcode = 7'd64 + 7'({$random(seed)} % 64);
			randomUop = u;
		end
	endfunction

	task checkValue(input string name, input logic [63:0] got, input logic [63:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			$display("** Error @ %0t: %s is %0h, expected %0h", $time, name, got, expected);
			errorCount++;
		end
	endtask

	// Offers one micro-op from a falling edge and returns after the edge that takes it
	task sendUop(input microOp_t u);
		int waited;
		begin
			waited = 0;
			@(negedge clk);
			inValid = 1'b1;
			inUop = u;
			while (!inReady && waited < timeoutCycles)
			begin
				@(negedge clk);
				waited++;
			end
			if (!inReady)
			begin
				$display("Timeout: the stage never took a micro-op at time %0t", $time);
				timeoutCount++;
			end
			else
				sentCount++;
			// With the output free the stage takes a new micro-op on every edge
			checkValue("acceptWait", waited, 0);
			@(posedge clk);
		end
	endtask

	task drainQueue;
		int waited;
		begin
			waited = 0;
			@(negedge clk);
			inValid = 1'b0;
			while (expQueue.size() != 0 && waited < timeoutCycles)
			begin
				@(negedge clk);
				waited++;
			end
			if (expQueue.size() != 0)
			begin
				$display("Timeout: %0d records never left the stage", expQueue.size());
				timeoutCount++;
			end
		end
	endtask

	// Stalls the output and offers a new micro-op every cycle until inReady drops
	task fillBuffers;
		int held;
		begin
			held = 0;
			@(negedge clk);
			outReady = 1'b0;
			while (inReady && held < 20)
			begin
				inValid = 1'b1;
				inUop = randomUop();
				held++;
				sentCount++;
				@(negedge clk);
			end
			inValid = 1'b0;
			if (inReady)
			begin
				$display("Timeout: inReady stayed high with the output stalled");
				timeoutCount++;
			end
			checkValue("heldItems", held, 4);
			repeat (5) @(negedge clk);
			checkValue("fullInReady", inReady, 0);
		end
	endtask

	// Random gaps on the input and random stalls on the output are decided per falling edge
	task runBackPressure(input int items);
		int sent;
		int cycles;
		logic readyAtOffer;
		begin
			sent = 0;
			cycles = 0;
			readyAtOffer = 1'b0;
			while (sent < items && cycles < items * 20)
			begin
				@(negedge clk);
				cycles++;
				// The offer made one falling edge ago went through if inReady was high then
				if (inValid && readyAtOffer)
				begin
					sent++;
					sentCount++;
				end
				outReady = ({$random(seed)} % 3) != 0;
				if (!inValid || readyAtOffer)
				begin
					inValid = sent < items && ({$random(seed)} % 4) != 0;
					if (inValid)
						inUop = randomUop();
				end
				readyAtOffer = inReady;
			end
			if (sent < items)
			begin
				$display("Timeout: only %0d of %0d micro-ops went in", sent, items);
				timeoutCount++;
			end
			@(negedge clk);
			inValid = 1'b0;
			outReady = 1'b1;
		end
	endtask

	// ========================================
	// Comparison process
	// ========================================

	always @(posedge clk)
	begin
		decodedUop_t expDec;
		int acceptCycle;
		if (arstN)
		begin
			// A stalled record has to hold until it is taken
			if (stalled)
			begin
				checkValue("stallValid", outValid, 1);
				checkValue("stallData", outDec, heldDec);
			end
			stalled = outValid && !outReady;
			heldDec = outDec;
			if (outValid && outReady)
			begin
				if (expQueue.size() == 0)
				begin
					$display("Unexpected output record with no micro-op left to match it");
					errorCount++;
				end
				else
				begin
					expDec = expQueue.pop_front();
					acceptCycle = cycleQueue.pop_front();
					deliveredCount++;
					checkValue("rd", outDec.rd, expDec.rd);
					checkValue("rs1", outDec.rs1, expDec.rs1);
					checkValue("rs2", outDec.rs2, expDec.rs2);
					checkValue("unit", outDec.unit, expDec.unit);
					checkValue("size", outDec.size, expDec.size);
					checkValue("pair", outDec.pair, expDec.pair);
					checkValue("isImm", outDec.isImm, expDec.isImm);
					checkValue("imm", outDec.imm, expDec.imm);
					checkValue("divu", outDec.divu, expDec.divu);
					checkValue("div", outDec.div, expDec.div);
					checkValue("mulu", outDec.mulu, expDec.mulu);
					checkValue("mul", outDec.mul, expDec.mul);
					checkValue("illegal", outDec.illegal, expDec.illegal);
					if (latencyCheck)
						checkValue("latency", cycleCount - acceptCycle, 2);
				end
			end
			if (inValid && inReady)
			begin
				expQueue.push_back(refDecode(inUop));
				cycleQueue.push_back(cycleCount);
				acceptedCount++;
			end
			cycleCount++;
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial
	begin
		microOp_t u;
		seed = 32'h7215_831c;
		timeoutCycles = 200;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		acceptedCount = 0;
		deliveredCount = 0;
		sentCount = 0;
		latencyCheck = 1'b0;
		stalled = 1'b0;
		heldDec = '0;
		arstN = 1'b0;
		inValid = 1'b0;
		inUop = '0;
		outReady = 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			checkValue("resetOutValid", outValid, 0);
			checkValue("resetInReady", inReady, 1);
		end
		arstN = 1'b1;
		@(negedge clk);
		checkValue("idleOutValid", outValid, 0);
		checkValue("idleInReady", inReady, 1);

		// Back-to-back directed micro-ops must each leave exactly two edges after entry
		latencyCheck = 1'b1;
		for (int op = 0; op < 9; op++)
		begin
			for (int fn = 0; fn < 8; fn++)
			begin
				u = $random(seed);
				u.opcode = r3Opcode(op);
				u.func = fnCode(fn);
				sendUop(u);
			end
		end
		for (int op = 0; op < 24; op++)
		begin
			u = $random(seed);
			u.opcode = otherOpcode(op % 8);
			sendUop(u);
		end
		// Unknown opcodes, then register forms with unknown func values
		for (int n = 0; n < 12; n++)
		begin
			u = $random(seed);
			u.opcode = 7'd64 + 7'({$random(seed)} % 64);
			sendUop(u);
			u.opcode = r3Opcode(n % 9);
			u.func = 7'd22 + 7'({$random(seed)} % 100);
			sendUop(u);
		end
		drainQueue();
		latencyCheck = 1'b0;

		fillBuffers();
		runBackPressure(300);
		drainQueue();
		checkValue("itemCount", deliveredCount, sentCount);

		$display("Checks: %0d, errors: %0d, timeouts: %0d, micro-ops: %0d",
			checkCount, errorCount, timeoutCount, acceptedCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: tb.f
decodePkg.sv
uopSkidBuffer.sv
uopDecodeDiv.sv
uopDecodeMul.sv
uopDecodeCore.sv
uopDecodeStage.sv
tbUopDecodeStage.sv

// File: run.sh
#!/bin/sh
# Build with Verilator from the file list, run once and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f tb.f --top-module tbUopDecodeStage -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
